//--- Makefile
# Verilator build and run for the host FIFO bridge logic

VERILATOR ?= verilator
TOP       ?= tb_host_dsp
RTL_TOP   ?= host_dsp_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		verilog/host_fifo_pkg.sv verilog/loopback_channel.sv \
		verilog/pulse_sequencer.sv verilog/to_host_arbiter.sv verilog/host_dsp_top.sv

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
verilog/host_fifo_pkg.sv
verilog/loopback_channel.sv
verilog/pulse_sequencer.sv
verilog/to_host_arbiter.sv
verilog/host_dsp_top.sv
sim/host_dsp_checker.sv
sim/tb_host_dsp.sv

//--- sim/host_dsp_checker.sv
/*
 * Scoreboard for the host FIFO bridge, samples DUT ports on the rising clock edge
 * Expected echo words, completion words and seq_out values come from the pattern file
 * done rises when every expected to-host word has been seen; read it away from the edge
 */
`timescale 1ns/1ps

module host_dsp_checker
(
   input  logic        clock,
   input  logic        rst_n,
   input  logic [63:0] fpc0_word,
   input  logic        fpc0_valid,
   input  logic        fpc0_read,
   input  logic        tpc_ready,
   input  logic        tpc_write,
   input  logic [63:0] tpc_word,
   input  logic        tpc_source,
   input  logic [3:0]  led,
   input  logic [15:0] seq_out,
   output logic        done,
   output int unsigned error_count,
   output int unsigned write_count,
   output int unsigned expected_writes
);

   import host_fifo_pkg::*;

   logic [67:0] pat_mem [0:31];                // Kind nibble over a 64-bit word
   logic [63:0] exp_echo [$];                  // Channel 0 words, in FIFO order
   logic [63:0] exp_done [$];                  // Sequencer completion words
   logic [63:0] cmd_list [$];                  // Channel 1 commands, for DELAY timing
   logic [15:0] exp_seq_out [$];
   logic [63:0] exp_word;
   logic [63:0] cmd;
   logic [3:0]  last_nibble;                   // LED nibble of the last pop
   logic        ready_d;                       // tpc_ready one edge back
   logic        first_cycle;
   logic [15:0] seq_count;
   int unsigned cycle;
   int unsigned last_seq_cycle;                // Edge of the previous sequencer write
   int          idx;

   initial $readmemh("sim/host_dsp_patterns.hex", pat_mem);

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         error_count++;
      end
   endtask

   task automatic report_problem(input string what);
      $display("Problem at %0t: %s", $time, what);
      error_count++;
   endtask

   always @(posedge clock)
   begin
      if (!rst_n)
      begin
         exp_echo.delete();
         exp_done.delete();
         cmd_list.delete();
         exp_seq_out.delete();
         idx = 0;
         while (idx < 32 && pat_mem[idx][67:64] != 4'hf)   // Kind f ends the list
         begin
            case (pat_mem[idx][67:64])
               4'h0: exp_echo.push_back(pat_mem[idx][63:0]);
               4'h1: cmd_list.push_back(pat_mem[idx][63:0]);
               4'h2: exp_done.push_back(pat_mem[idx][63:0]);
               4'h3: exp_seq_out.push_back(pat_mem[idx][15:0]);
               default: ;
            endcase
            idx++;
         end
         expected_writes = exp_echo.size() + cmd_list.size();
         error_count     = 0;
         write_count     = 0;
         done            = 1'b0;
         last_nibble     = 4'h5;               // LED pattern out of reset
         ready_d         = 1'b0;
         first_cycle     = 1'b1;
         seq_count       = 16'h0;
         cycle           = 0;
         last_seq_cycle  = 0;
      end
      else
      begin
         cycle++;
         if (first_cycle)
            check_value("led", 64'(led), 64'h5);
         first_cycle = 1'b0;
         if (tpc_write)
         begin
            write_count++;
            if (!ready_d)
               report_problem("write strobe right after a cycle with tpc_ready low");
            if (int'(tpc_source) == peer_loopback)
            begin
               if (exp_echo.size() == 0)
                  report_problem("loopback write with no channel 0 word left to echo");
               else
               begin
                  exp_word = exp_echo.pop_front();
                  check_value("tpc_word", tpc_word, exp_word);
                  check_value("led", 64'(led), 64'(last_nibble));
               end
            end
            else if (exp_done.size() == 0 || cmd_list.size() == 0 || exp_seq_out.size() == 0)
               report_problem("sequencer write with no command outstanding");
            else
            begin
               exp_word = exp_done.pop_front();
               cmd      = cmd_list.pop_front();
               seq_count++;                    // One per command, unknown opcodes too
               check_value("tpc_word", tpc_word, exp_word);
               check_value("tpc_word count", 64'(tpc_word[15:0]), 64'(seq_count));
               check_value("seq_out", 64'(seq_out), 64'(exp_seq_out.pop_front()));
               if (cmd[63:56] == op_delay && (cycle - last_seq_cycle) < cmd[31:0])
                  report_problem("DELAY completion came before its cycle count ran out");
               last_seq_cycle = cycle;
            end
         end
         if (fpc0_read && fpc0_valid)
            last_nibble = fpc0_word[3:0];      // LEDs follow at this same edge
         ready_d = tpc_ready;
         done    = (exp_echo.size() == 0) && (exp_done.size() == 0);
      end
   end

endmodule

//--- sim/host_dsp_patterns.hex
// Each line is one digit of record kind followed by a 64-bit word, 17 hex digits
// Kind 0 ch0 word, 1 ch1 command, 2 expected completion word, 3 expected seq_out, f end
00123456789abcdef
0fedcba9876543210
05555aaaa5555aaa3
00000000000000000
013579bdf2468ace8
// SET a5c3
1010000000000a5c3
20100000000000001
3000000000000a5c3
// DELAY 12, reserved bits set
102abcdef0000000c
20200000000000002
3000000000000a5c3
// Unknown opcode
17f00000000001234
27f00000000000003
3000000000000a5c3
// SET 0f0f, reserved bits set
101ffffffffff0f0f
20100000000000004
30000000000000f0f
// DELAY 0
10200000000000000
20200000000000005
30000000000000f0f
f0000000000000000

//--- sim/tb_host_dsp.sv
/*
 * Top-level testbench for host_dsp_top
 * Both from-host FIFOs are first-word-fall-through queues loaded from the pattern file
 * tpc_ready drops at random, about one cycle in four, with a fixed seed
 */
`timescale 1ns/1ps

module tb_host_dsp;

   localparam int timeout_cycles = 2000;       // Whole run, far above the pattern length
   localparam int drain_cycles   = 20;         // Quiet time to catch stray writes

   logic        clock;
   logic        rst_n      = 1'b0;
   logic [63:0] fpc0_word  = 64'h0;
   logic        fpc0_valid = 1'b0;
   logic [63:0] fpc1_word  = 64'h0;
   logic        fpc1_valid = 1'b0;
   logic        tpc_ready  = 1'b0;
   logic        fpc0_read;
   logic        fpc1_read;
   logic        tpc_write;
   logic [63:0] tpc_word;
   logic        tpc_source;
   logic [3:0]  led;
   logic [15:0] seq_out;
   logic        done;
   int unsigned error_count;
   int unsigned write_count;
   int unsigned expected_writes;

   logic [67:0] pat_mem [0:31];
   logic [63:0] ch0_fifo [$];                  // From-host channel 0 contents
   logic [63:0] ch1_fifo [$];                  // From-host channel 1 contents
   integer      seed = 32'h9ae5_4866;
   int unsigned wait_cycles;
   logic        failed;

   host_dsp_top uut
   (
      .clock(clock), .rst_n(rst_n),
      .fpc0_word(fpc0_word), .fpc0_valid(fpc0_valid), .fpc0_read(fpc0_read),
      .fpc1_word(fpc1_word), .fpc1_valid(fpc1_valid), .fpc1_read(fpc1_read),
      .tpc_ready(tpc_ready), .tpc_write(tpc_write), .tpc_word(tpc_word),
      .tpc_source(tpc_source), .led(led), .seq_out(seq_out)
   );

   host_dsp_checker u_checker
   (
      .clock(clock), .rst_n(rst_n),
      .fpc0_word(fpc0_word), .fpc0_valid(fpc0_valid), .fpc0_read(fpc0_read),
      .tpc_ready(tpc_ready), .tpc_write(tpc_write), .tpc_word(tpc_word),
      .tpc_source(tpc_source), .led(led), .seq_out(seq_out),
      .done(done), .error_count(error_count), .write_count(write_count),
      .expected_writes(expected_writes)
   );

   initial $readmemh("sim/host_dsp_patterns.hex", pat_mem);

   initial
   begin
      clock = 1'b0;
      forever #5 clock = ~clock;               // 100 MHz
   end

   // Kind 0 records feed channel 0, kind 1 feed channel 1
   task automatic load_host_fifos();
      int i;
      ch0_fifo.delete();
      ch1_fifo.delete();
      i = 0;
      while (i < 32 && pat_mem[i][67:64] != 4'hf)
      begin
         if (pat_mem[i][67:64] == 4'h0)
            ch0_fifo.push_back(pat_mem[i][63:0]);
         else if (pat_mem[i][67:64] == 4'h1)
            ch1_fifo.push_back(pat_mem[i][63:0]);
         i++;
      end
   endtask

   // FWFT models, a read while valid consumes the head word
   always @(posedge clock)
   begin
      if (!rst_n)
      begin
         load_host_fifos();
         fpc0_valid <= 1'b0;
         fpc1_valid <= 1'b0;
      end
      else
      begin
         if (fpc0_read && fpc0_valid)
            void'(ch0_fifo.pop_front());
         if (fpc1_read && fpc1_valid)
            void'(ch1_fifo.pop_front());
         fpc0_valid <= (ch0_fifo.size() != 0);
         fpc0_word  <= (ch0_fifo.size() != 0) ? ch0_fifo[0] : 64'h0;
         fpc1_valid <= (ch1_fifo.size() != 0);
         fpc1_word  <= (ch1_fifo.size() != 0) ? ch1_fifo[0] : 64'h0;
      end
   end

   // Random back-pressure on the to-host side
   always @(posedge clock)
   begin
      if (!rst_n)
         tpc_ready <= 1'b1;
      else
         tpc_ready <= (($random(seed) & 3) != 0);
   end

   initial
   begin
      failed      = 1'b0;
      wait_cycles = 0;
      repeat (5) @(posedge clock);
      rst_n <= 1'b1;
      while (!done && wait_cycles < timeout_cycles)
      begin
         @(negedge clock);                     // Checker outputs settle mid-cycle
         wait_cycles++;
      end
      if (!done)
      begin
         $display("Timeout: to-host words still missing after %0d cycles", wait_cycles);
         failed = 1'b1;
      end
      wait_cycles = 0;
      while (wait_cycles < drain_cycles)
      begin
         @(negedge clock);
         wait_cycles++;
      end
      if (write_count != expected_writes)
      begin
         $display("Write count on the to-host port does not match the pattern file");
         failed = 1'b1;
      end
      $display("Result: %0d errors, %0d writes, %0d expected", error_count, write_count,
               expected_writes);
      if (failed || error_count != 0)
         $display("TEST FAIL");
      else
         $display("TEST PASS");
      $finish;
   end

endmodule

//--- verilog/host_dsp_top.sv
/*
 * FPGA-side logic behind the host FIFO bridge, one clock domain
 * Channel 0 is echoed back by the loopback peer, channel 1 feeds the sequencer
 * Both peers share the to-host port, and tpc_source tells them apart
 * From-host inputs are first-word-fall-through; tpc_ready means room for two words
 */
`timescale 1ns/1ps

module host_dsp_top
(
   input  logic        clock,
   input  logic        rst_n,
   // From-host channel 0, loopback
   input  logic [63:0] fpc0_word,
   input  logic        fpc0_valid,
   output logic        fpc0_read,
   // From-host channel 1, sequencer commands
   input  logic [63:0] fpc1_word,
   input  logic        fpc1_valid,
   output logic        fpc1_read,
   // Shared to-host port
   input  logic        tpc_ready,
   output logic        tpc_write,
   output logic [63:0] tpc_word,
   output logic        tpc_source,
   // Board outputs
   output logic [3:0]  led,
   output logic [15:0] seq_out
);

   import host_fifo_pkg::*;

   tpc_req_t               lb_req;
   tpc_req_t               seq_req;
   tpc_req_t               peer_req [num_peers];   // Indexed by source tag
   logic [num_peers-1:0]   peer_grant;

   assign peer_req[peer_loopback]  = lb_req;
   assign peer_req[peer_sequencer] = seq_req;

   loopback_channel u_loopback
   (
      .clock     (clock),
      .rst_n     (rst_n),
      .fpc_word  (fpc0_word),
      .fpc_valid (fpc0_valid),
      .fpc_read  (fpc0_read),
      .req       (lb_req),
      .grant     (peer_grant[peer_loopback]),
      .led       (led)
   );

   pulse_sequencer u_sequencer
   (
      .clock     (clock),
      .rst_n     (rst_n),
      .fpc_word  (fpc1_word),
      .fpc_valid (fpc1_valid),
      .fpc_read  (fpc1_read),
      .req       (seq_req),
      .grant     (peer_grant[peer_sequencer]),
      .seq_out   (seq_out)
   );

   to_host_arbiter u_arbiter
   (
      .clock      (clock),
      .rst_n      (rst_n),
      .req        (peer_req),
      .grant      (peer_grant),
      .tpc_ready  (tpc_ready),
      .tpc_write  (tpc_write),
      .tpc_word   (tpc_word),
      .tpc_source (tpc_source)
   );

endmodule

//--- verilog/host_fifo_pkg.sv
/*
 * Shared constants and types for the host FIFO bridge logic
 * Every FIFO word is 64 bits, and the to-host port is shared by exactly two peers
 * Sequencer command words are decoded as either a SET or a DELAY view of one word
 * Opcodes other than SET and DELAY are legal and only produce a completion word
 */
package host_fifo_pkg;

   // FIFO geometry
   localparam int word_width = 64;             // Host FIFO word, both directions

   // To-host requesters
   localparam int num_peers = 2;
   localparam int tag_width = (num_peers > 1) ? $clog2(num_peers) : 1;

   // Source tags, also the arbiter request index
   localparam int peer_loopback  = 0;
   localparam int peer_sequencer = 1;

   // Sequencer opcodes, top byte of a command
   localparam logic [7:0] op_set   = 8'h01;    // Load seq_out
   localparam logic [7:0] op_delay = 8'h02;    // Wait a number of clocks

   localparam logic [3:0] led_reset_value = 4'h5;   // LED pattern until first channel 0 word

   // SET command layout
   typedef struct packed
   {
      logic [7:0]  opcode;
      logic [39:0] reserved;                   // Ignored on input
      logic [15:0] value;                      // New seq_out value
   } seq_set_t;

   // DELAY command layout
   typedef struct packed
   {
      logic [7:0]  opcode;
      logic [23:0] reserved;                   // Ignored on input
      logic [31:0] cycles;                     // Zero completes without waiting
   } seq_delay_t;

   // One command word, read raw or through either command view
   typedef union packed
   {
      logic [word_width-1:0] raw;
      seq_set_t              set_view;
      seq_delay_t            delay_view;
   } seq_cmd_u;

   // Peer request to the to-host arbiter
   // Word must stay stable while pending is high and no grant was seen
   typedef struct packed
   {
      logic                  pending;          // Word waiting for the host
      logic [word_width-1:0] word;
   } tpc_req_t;

endpackage

//--- verilog/loopback_channel.sv
/*
 * Echo of from-host channel 0 back to the host
 * Holds one word at a time, so a new word is popped only after the held one is granted
 * The LEDs follow bits 3:0 of each popped word, starting from the reset pattern
 */
`timescale 1ns/1ps

module loopback_channel
(
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic [63:0]             fpc_word,   // FWFT data, valid with fpc_valid
   input  logic                    fpc_valid,
   output logic                    fpc_read,
   output host_fifo_pkg::tpc_req_t req,
   input  logic                    grant,
   output logic [3:0]              led
);

   import host_fifo_pkg::*;

   logic        pop;                           // Word consumed at this edge
   logic        pending;                       // Held word not yet granted
   logic [63:0] held_word;

   assign pop = fpc_read && fpc_valid;

   // Read enable, holding flag and LEDs
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fpc_read <= 1'b0;
         pending  <= 1'b0;
         led      <= led_reset_value;
      end
      else if (pop)
      begin
         fpc_read <= 1'b0;                     // Hold off until the echo is granted
         pending  <= 1'b1;
         led      <= fpc_word[3:0];
      end
      else if (grant)
      begin
         pending  <= 1'b0;
         fpc_read <= 1'b1;                     // Holding register free again
      end
      else if (!pending)
      begin
         fpc_read <= 1'b1;
      end
   end

   // Echo payload
   always_ff @(posedge clock)
   begin
      if (pop)
         held_word <= fpc_word;
   end

   assign req.pending = pending;
   assign req.word    = held_word;

   // Holding register is single entry
   a_no_pop_while_pending : assert property
      (@(posedge clock) disable iff (!rst_n) pop |-> !pending);

endmodule

//--- verilog/pulse_sequencer.sv
/*
 * Command-driven pulse sequencer on from-host channel 1
 * One command in flight; the next is popped once its completion word is granted
 * Completion word is the opcode, 40 zero bits and a 16-bit running count
 * The count wraps after 65535 commands
 */
`timescale 1ns/1ps

module pulse_sequencer
(
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic [63:0]             fpc_word,   // FWFT command word
   input  logic                    fpc_valid,
   output logic                    fpc_read,
   output host_fifo_pkg::tpc_req_t req,
   input  logic                    grant,
   output logic [15:0]             seq_out
);

   import host_fifo_pkg::*;

   typedef enum logic [1:0]
   {
      st_idle,                                 // Waiting for a command
      st_execute,                              // Decode and act, one cycle
      st_delay,                                // Counting down a DELAY
      st_report                                // Completion word pending
   } seq_state_t;

   seq_state_t  state;
   seq_cmd_u    cmd_q;                         // Command under execution
   logic        pop;
   logic [31:0] delay_cnt;                     // Cycles left in st_delay
   logic [15:0] done_count;                    // Commands granted so far

   assign pop = fpc_read && fpc_valid;

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= st_idle;
         fpc_read   <= 1'b0;
         seq_out    <= 16'h0;
         delay_cnt  <= 32'h0;
         done_count <= 16'h0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (pop)
               begin
                  fpc_read <= 1'b0;
                  state    <= st_execute;
               end
               else
               begin
                  fpc_read <= 1'b1;            // Keep asking until a command shows up
               end
            end

            st_execute:
            begin
               case (cmd_q.set_view.opcode)
                  op_set:
                  begin
                     seq_out <= cmd_q.set_view.value;
                     state   <= st_report;
                  end
                  op_delay:
                  begin
                     if (cmd_q.delay_view.cycles == 32'h0)
                        state <= st_report;    // Zero delay completes at once
                     else
                     begin
                        delay_cnt <= cmd_q.delay_view.cycles;
                        state     <= st_delay;
                     end
                  end
                  default:
                  begin
                     state <= st_report;       // Unknown opcode, completion only
                  end
               endcase
            end

            st_delay:
            begin
               delay_cnt <= delay_cnt - 32'd1;
               if (delay_cnt == 32'd1)
                  state <= st_report;          // Last delay cycle
            end

            st_report:
            begin
               if (grant)
               begin
                  done_count <= done_count + 16'd1;
                  fpc_read   <= 1'b1;          // Pop the next command right away
                  state      <= st_idle;
               end
            end

            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Command capture, payload only
   always_ff @(posedge clock)
   begin
      if (pop)
         cmd_q.raw <= fpc_word;
   end

   // Count in the word already includes this command
   assign req.pending = (state == st_report);
   assign req.word    = {cmd_q.set_view.opcode, 40'h0, done_count + 16'd1};

   // Countdown always leaves st_delay before reaching zero
   a_delay_no_underflow : assert property
      (@(posedge clock) disable iff (!rst_n) (state == st_delay) |-> (delay_cnt != 32'h0));

endmodule

//--- verilog/to_host_arbiter.sv
/*
 * Round-robin arbiter for the single to-host write port
 * Grant is combinational and only given while tpc_ready is high
 * Word and source tag are registered, so the write comes one cycle after grant
 * The source tag port is one bit, which limits this block to two peers
 */
`timescale 1ns/1ps

module to_host_arbiter
(
   input  logic                                  clock,
   input  logic                                  rst_n,
   input  host_fifo_pkg::tpc_req_t               req [host_fifo_pkg::num_peers],
   output logic [host_fifo_pkg::num_peers-1:0]   grant,
   input  logic                                  tpc_ready,   // Room for two more words
   output logic                                  tpc_write,
   output logic [63:0]                           tpc_word,
   output logic                                  tpc_source   // Index of the winning peer
);

   import host_fifo_pkg::*;

   logic [tag_width-1:0] last_winner;          // Peer granted most recently
   logic [tag_width-1:0] pick;                 // Round-robin choice this cycle
   logic                 pick_valid;           // Some peer is pending
   logic                 issue;                // Grant happens at this edge
   int unsigned          cand;

   // Search starts just after the last winner
   always_comb
   begin
      pick_valid = 1'b0;
      pick       = last_winner;
      cand       = 0;
      for (int unsigned off = 1; off <= num_peers; off++)
      begin
         cand = (int'(last_winner) + off) % num_peers;
         if (!pick_valid && req[cand].pending)
         begin
            pick       = cand[tag_width-1:0];
            pick_valid = 1'b1;
         end
      end
   end

   assign issue = tpc_ready && pick_valid;

   always_comb
   begin
      grant = '0;
      if (issue)
         grant[pick] = 1'b1;
   end

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tpc_write   <= 1'b0;
         last_winner <= tag_width'(num_peers - 1);   // Peer 0 wins the first tie
      end
      else
      begin
         tpc_write <= issue;
         if (issue)
            last_winner <= pick;
      end
   end

   // Registered port word and source tag
   always_ff @(posedge clock)
   begin
      if (issue)
      begin
         tpc_word   <= req[pick].word;
         tpc_source <= pick;
      end
   end

   a_grant_onehot0 : assert property
      (@(posedge clock) disable iff (!rst_n) $onehot0(grant));

endmodule
